// ==== src.f ====
+incdir+src
src/fetch_pkg.sv
src/fetch_pc.sv
src/imem.sv
src/fetch_lane.sv
src/fetch_bundle.sv
src/fetch_unit.sv
tb/fetch_unit_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= fetch_unit_tb
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_MSG  ?= Result: PASSED

SOURCES := $(wildcard src/*.sv src/*.svh tb/*.sv)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== tb/fetch_unit_tb.sv ====
// Self-checking testbench for fetch_unit: memory preload, stimulus table and reference model
`timescale 1ns/1ps
`include "fetch_defs.svh"

module fetch_unit_tb;

    localparam int CLK_PERIOD   = 10;
    localparam int RESET_CYCLES = 8;
    localparam int W            = `FETCH_WIDTH;
    localparam int LW           = `LANE_IDX_WIDTH;
    localparam int AW           = `IMEM_ADDR_WIDTH;
    localparam int LOAD_CYCLES  = `IMEM_DEPTH;
    localparam int RANDOM_ROWS  = 64;

    // One row is one cycle of control inputs
    typedef struct packed {
        logic                   en;
        logic                   flush;
        logic [`ADDR_WIDTH-1:0] flush_target;
        logic                   pred_valid;
        logic                   pred_taken;
        logic [LW-1:0]          pred_lane;
        logic [`ADDR_WIDTH-1:0] pred_target;
    } row_t;

    logic                             clock;
    logic                             reset;
    logic                             fetch_en_i;
    logic                             flush_i;
    logic [`ADDR_WIDTH-1:0]           flush_target_i;
    logic                             pred_valid_i;
    logic                             pred_taken_i;
    logic [LW-1:0]                    pred_lane_i;
    logic [`ADDR_WIDTH-1:0]           pred_target_i;
    logic                             load_en_i;
    logic [AW-1:0]                    load_addr_i;
    logic [`BLOCK_WIDTH-1:0]          load_data_i;
    logic [W-1:0]                     if_valid_o;
    logic [W-1:0][`ADDR_WIDTH-1:0]    if_pc_o;
    logic [W-1:0][`ADDR_WIDTH-1:0]    if_npc_o;
    logic [W-1:0][31:0]               if_inst_o;

    // Word copy of the memory, indexed by PC bits above the byte offset
    logic [31:0]            mem_copy [2*`IMEM_DEPTH];

    // Reference model, a request stage and an output stage
    logic [`ADDR_WIDTH-1:0] m_pc;
    logic                   m_req_v;
    logic [`ADDR_WIDTH-1:0] m_req_pc;
    logic [LW-1:0]          m_req_last;
    logic                   m_out_v;
    logic [`ADDR_WIDTH-1:0] m_out_pc;
    logic [LW-1:0]          m_out_last;

    integer seed        = 32'h350c;
    int     error_count = 0;
    bit     table_ready = 1'b0;
    row_t   rows[$];

    fetch_unit dut0 (
        .clock          (clock),
        .reset          (reset),
        .fetch_en_i     (fetch_en_i),
        .flush_i        (flush_i),
        .flush_target_i (flush_target_i),
        .pred_valid_i   (pred_valid_i),
        .pred_taken_i   (pred_taken_i),
        .pred_lane_i    (pred_lane_i),
        .pred_target_i  (pred_target_i),
        .load_en_i      (load_en_i),
        .load_addr_i    (load_addr_i),
        .load_data_i    (load_data_i),
        .if_valid_o     (if_valid_o),
        .if_pc_o        (if_pc_o),
        .if_npc_o       (if_npc_o),
        .if_inst_o      (if_inst_o)
    );

    initial begin
        clock = 1'b0;
        forever #(CLK_PERIOD / 2) clock = ~clock;
    end

    // ----------------------------------------------------------------------
    // Stimulus table
    // ----------------------------------------------------------------------

    function automatic void add_row(input logic en, input logic flush,
                                    input logic [31:0] ft, input logic pv,
                                    input logic pt, input logic [LW-1:0] pl,
                                    input logic [31:0] ptgt);
        row_t r;
        r = '{en, flush, ft, pv, pt, pl, ptgt};
        rows.push_back(r);
    endfunction

    function automatic void add_seq(input int n);
        for (int i = 0; i < n; i++) begin
            add_row(1'b1, 1'b0, '0, 1'b0, 1'b0, LW'(0), '0);
        end
    endfunction

    function automatic void add_stall(input int n);
        for (int i = 0; i < n; i++) begin
            add_row(1'b0, 1'b0, '0, 1'b0, 1'b0, LW'(0), '0);
        end
    endfunction

    function automatic void build_table();
        logic [31:0] r1;
        logic [31:0] r2;
        add_seq(4);
        // Taken in lane 0 cuts lane 1
        add_row(1'b1, 1'b0, '0, 1'b1, 1'b1, LW'(0), 32'h0000_0100);
        add_seq(2);
        // Taken in the last lane, target in the upper half of a block
        add_row(1'b1, 1'b0, '0, 1'b1, 1'b1, LW'(W - 1), 32'h0000_0204);
        add_seq(2);
        // Not taken keeps the sequential path
        add_row(1'b1, 1'b0, '0, 1'b1, 1'b0, LW'(0), 32'h0000_0500);
        add_stall(2);
        add_seq(2);
        // Flush beats a same-cycle taken prediction
        add_row(1'b1, 1'b1, 32'h0000_0040, 1'b1, 1'b1, LW'(0), 32'h0000_0300);
        add_seq(4);
        // Back-to-back flushes, the second one wraps the memory
        add_row(1'b1, 1'b1, 32'h0000_0600, 1'b0, 1'b0, LW'(0), '0);
        add_row(1'b1, 1'b1, 32'h0000_07f8, 1'b0, 1'b0, LW'(0), '0);
        add_seq(3);
        // Flush during a stall
        add_row(1'b0, 1'b1, 32'h0000_0010, 1'b0, 1'b0, LW'(0), '0);
        add_seq(3);
        // Random stretch, about one flush in eight
        for (int i = 0; i < RANDOM_ROWS; i++) begin
            r1 = $random(seed);
            r2 = $random(seed);
            add_row(r1[0] | r1[1], r1[4:2] == 3'd0, {21'h0, r2[10:2], 2'b00},
                    r1[5], r1[6], r1[7 +: LW], {21'h0, r2[26:18], 2'b00});
        end
        // Drain
        add_stall(3);
    endfunction

    // ----------------------------------------------------------------------
    // Driving, model and checks
    // ----------------------------------------------------------------------

    task automatic report_failure();
        error_count++;
        $display("Result: FAILED");
        $fatal(1, "Run stopped at the first failure");
    endtask

    task automatic check_value(input string name, input int lane,
                               input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            $display("** Error at %0t: %s[%0d] is %h, expected %h",
                     $time, name, lane, got, exp);
            report_failure();
        end
    endtask

    task automatic preload_memory();
        logic [31:0] rnd;
        logic [31:0] word [2];
        for (int b = 0; b < `IMEM_DEPTH; b++) begin
            for (int i = 0; i < 2; i++) begin
                rnd = $random(seed);
                // Block index on top, word slot in bit 0
                word[i] = {16'(b), rnd[15:1], 1'(i)};
                mem_copy[2 * b + i] = word[i];
            end
            @(posedge clock);
            #2;
            load_en_i   = 1'b1;
            load_addr_i = AW'(b);
            load_data_i = {word[1], word[0]};
        end
        @(posedge clock);
        #2;
        load_en_i = 1'b0;
    endtask

    task automatic drive_row(input row_t r);
        fetch_en_i     = r.en;
        flush_i        = r.flush;
        flush_target_i = r.flush_target;
        pred_valid_i   = r.pred_valid;
        pred_taken_i   = r.pred_taken;
        pred_lane_i    = r.pred_lane;
        pred_target_i  = r.pred_target;
    endtask

    // State after the next edge for one applied row
    task automatic step_model(input row_t r);
        logic taken;
        taken      = r.pred_valid && r.pred_taken;
        m_out_v    = m_req_v && !r.flush;
        m_out_pc   = m_req_pc;
        m_out_last = m_req_last;
        m_req_v    = r.en && !r.flush;
        m_req_pc   = m_pc;
        m_req_last = taken ? r.pred_lane : LW'(W - 1);
        if (r.flush) begin
            m_pc = r.flush_target;
        end else if (r.en) begin
            m_pc = taken ? r.pred_target : m_pc + 32'(4 * W);
        end
    endtask

    task automatic check_outputs();
        logic        exp_v;
        logic [31:0] exp_pc;
        for (int l = 0; l < W; l++) begin
            exp_v  = m_out_v && (l <= int'(m_out_last));
            exp_pc = m_out_pc + 32'(4 * l);
            check_value("if_valid_o", l, 32'(if_valid_o[l]), 32'(exp_v));
            if (exp_v) begin
                check_value("if_pc_o", l, if_pc_o[l], exp_pc);
                check_value("if_npc_o", l, if_npc_o[l], exp_pc + 32'd4);
                check_value("if_inst_o", l, if_inst_o[l], mem_copy[exp_pc[AW+2:2]]);
            end else begin
                check_value("if_inst_o", l, if_inst_o[l], `NOP);
            end
        end
    endtask

    // ----------------------------------------------------------------------
    // Main sequence and watchdog
    // ----------------------------------------------------------------------

    initial begin : main
        reset          = 1'b1;
        fetch_en_i     = 1'b0;
        flush_i        = 1'b0;
        flush_target_i = '0;
        pred_valid_i   = 1'b0;
        pred_taken_i   = 1'b0;
        pred_lane_i    = '0;
        pred_target_i  = '0;
        load_en_i      = 1'b0;
        load_addr_i    = '0;
        load_data_i    = '0;
        build_table();
        table_ready = 1'b1;
        repeat (RESET_CYCLES) @(posedge clock);
        #2;
        reset = 1'b0;
        // Nothing valid out of reset
        repeat (2) @(posedge clock);
        #1;
        for (int l = 0; l < W; l++) begin
            check_value("if_valid_o", l, 32'(if_valid_o[l]), 32'd0);
        end
        preload_memory();
        // PC held at reset value while fetch was disabled
        m_pc       = `RESET_PC;
        m_req_v    = 1'b0;
        m_req_pc   = '0;
        m_req_last = '0;
        m_out_v    = 1'b0;
        m_out_pc   = '0;
        m_out_last = '0;
        // Sample 1 ns after the edge, drive 2 ns after it
        foreach (rows[i]) begin
            @(posedge clock);
            #1;
            check_outputs();
            #1;
            drive_row(rows[i]);
            step_model(rows[i]);
        end
        @(posedge clock);
        #1;
        check_outputs();
        if (error_count == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    initial begin : watchdog
        wait (table_ready);
        #((rows.size() + LOAD_CYCLES + 20) * CLK_PERIOD);
        $display("Watchdog expired before the stimulus table was finished");
        report_failure();
    end

endmodule

// ==== src/fetch_unit.sv ====
// Fetch subsystem top: PC generator, banked memory, lane slices and output register, 2-cycle latency
`timescale 1ns/1ps
`include "fetch_defs.svh"

module fetch_unit import fetch_pkg::*; (
    input  logic                                        clock,
    input  logic                                        reset,
    // Stall when low
    input  logic                                        fetch_en_i,
    // Redirect from execute
    input  logic                                        flush_i,
    input  logic [`ADDR_WIDTH-1:0]                      flush_target_i,
    // Branch prediction for the bundle at the current PC
    input  logic                                        pred_valid_i,
    input  logic                                        pred_taken_i,
    input  logic [`LANE_IDX_WIDTH-1:0]                  pred_lane_i,
    input  logic [`ADDR_WIDTH-1:0]                      pred_target_i,
    // Memory preload port
    input  logic                                        load_en_i,
    input  logic [`IMEM_ADDR_WIDTH-1:0]                 load_addr_i,
    input  logic [`BLOCK_WIDTH-1:0]                     load_data_i,
    // Fetch packet to dispatch, one entry per lane
    output logic [`FETCH_WIDTH-1:0]                     if_valid_o,
    output logic [`FETCH_WIDTH-1:0][`ADDR_WIDTH-1:0]    if_pc_o,
    output logic [`FETCH_WIDTH-1:0][`ADDR_WIDTH-1:0]    if_npc_o,
    output inst_t [`FETCH_WIDTH-1:0]                    if_inst_o
);

    // PC generator to memory
    mem_command_e                                 imem_command;
    logic [`ADDR_WIDTH-1:0]                       imem_addr;

    // Memory to lanes
    logic [`FETCH_WIDTH-1:0][`BLOCK_WIDTH-1:0]    blocks;

    // Request in flight
    logic                                         req_valid;
    logic [`ADDR_WIDTH-1:0]                       req_pc;
    logic [`LANE_IDX_WIDTH-1:0]                   req_last_lane;

    // Lanes to output register
    logic [`FETCH_WIDTH-1:0]                      lane_valid;
    logic [`FETCH_WIDTH-1:0][`ADDR_WIDTH-1:0]     lane_pc;
    logic [`FETCH_WIDTH-1:0][`ADDR_WIDTH-1:0]     lane_npc;
    inst_t [`FETCH_WIDTH-1:0]                     lane_inst;

    // ------------------------------------------------------------------
    // Cycle n: PC and load strobe
    // ------------------------------------------------------------------

    fetch_pc u_fetch_pc (
        .clock           (clock),
        .reset           (reset),
        .fetch_en_i      (fetch_en_i),
        .flush_i         (flush_i),
        .flush_target_i  (flush_target_i),
        .pred_valid_i    (pred_valid_i),
        .pred_taken_i    (pred_taken_i),
        .pred_lane_i     (pred_lane_i),
        .pred_target_i   (pred_target_i),
        .imem_command_o  (imem_command),
        .imem_addr_o     (imem_addr),
        .req_valid_o     (req_valid),
        .req_pc_o        (req_pc),
        .req_last_lane_o (req_last_lane)
    );

    imem u_imem (
        .clock          (clock),
        .imem_command_i (imem_command),
        .imem_addr_i    (imem_addr),
        .load_en_i      (load_en_i),
        .load_addr_i    (load_addr_i),
        .load_data_i    (load_data_i),
        .blocks_o       (blocks)
    );

    // ------------------------------------------------------------------
    // Cycle n+1: lane packing, registered at its end
    // ------------------------------------------------------------------

    for (genvar g = 0; g < `FETCH_WIDTH; g++) begin : g_lane
        fetch_lane #(
            .LANE (g)
        ) u_fetch_lane (
            .req_valid_i     (req_valid),
            .req_pc_i        (req_pc),
            .req_last_lane_i (req_last_lane),
            .block_i         (blocks[g]),
            .lane_valid_o    (lane_valid[g]),
            .lane_pc_o       (lane_pc[g]),
            .lane_npc_o      (lane_npc[g]),
            .lane_inst_o     (lane_inst[g])
        );
    end

    fetch_bundle u_fetch_bundle (
        .clock        (clock),
        .reset        (reset),
        .flush_i      (flush_i),
        .lane_valid_i (lane_valid),
        .lane_pc_i    (lane_pc),
        .lane_npc_i   (lane_npc),
        .lane_inst_i  (lane_inst),
        .if_valid_o   (if_valid_o),
        .if_pc_o      (if_pc_o),
        .if_npc_o     (if_npc_o),
        .if_inst_o    (if_inst_o)
    );

endmodule

// ==== src/fetch_bundle.sv ====
// Fetch output register: collects all lanes into the dispatch packet and drops flushed bundles
`timescale 1ns/1ps
`include "fetch_defs.svh"

module fetch_bundle import fetch_pkg::*; (
    input  logic                                        clock,
    input  logic                                        reset,
    // Kills the bundle being registered this cycle
    input  logic                                        flush_i,
    // Combinational lane results
    input  logic [`FETCH_WIDTH-1:0]                     lane_valid_i,
    input  logic [`FETCH_WIDTH-1:0][`ADDR_WIDTH-1:0]    lane_pc_i,
    input  logic [`FETCH_WIDTH-1:0][`ADDR_WIDTH-1:0]    lane_npc_i,
    input  inst_t [`FETCH_WIDTH-1:0]                    lane_inst_i,
    // Registered fetch packet to dispatch
    output logic [`FETCH_WIDTH-1:0]                     if_valid_o,
    output logic [`FETCH_WIDTH-1:0][`ADDR_WIDTH-1:0]    if_pc_o,
    output logic [`FETCH_WIDTH-1:0][`ADDR_WIDTH-1:0]    if_npc_o,
    output inst_t [`FETCH_WIDTH-1:0]                    if_inst_o
);

    // Instruction words entering the register
    inst_t [`FETCH_WIDTH-1:0] inst_next;

    // Helper for the contiguity check
    logic  [`FETCH_WIDTH-1:0] valid_plus_one;

    // ------------------------------------------------------------------
    // Valid bits
    // ------------------------------------------------------------------

    // Reset and flush clear the whole bundle
    always_ff @(posedge clock) begin
        if (reset || flush_i) begin
            if_valid_o <= '0;
        end else begin
            if_valid_o <= lane_valid_i;
        end
    end

    // ------------------------------------------------------------------
    // Payload
    // ------------------------------------------------------------------

    // Flushed lanes show NOP like any other invalid lane
    always_comb begin
        for (int l = 0; l < `FETCH_WIDTH; l++) begin
            inst_next[l] = flush_i ? inst_t'(`NOP) : lane_inst_i[l];
        end
    end

    always_ff @(posedge clock) begin
        if_pc_o   <= lane_pc_i;
        if_npc_o  <= lane_npc_i;
        if_inst_o <= inst_next;
    end

    // ------------------------------------------------------------------
    // Checks
    // ------------------------------------------------------------------

    assign valid_plus_one = if_valid_o + `FETCH_WIDTH'(1);

    // Masking only cuts the tail, so valid lanes start at lane 0
    a_valid_contiguous: assert property (
        @(posedge clock) disable iff (reset)
        (if_valid_o & valid_plus_one) == '0
    );

endmodule

// ==== src/fetch_lane.sv ====
// One fetch lane: word select from its memory block, PC and NPC, and masking after a taken branch
`timescale 1ns/1ps
`include "fetch_defs.svh"

module fetch_lane import fetch_pkg::*; #(
    // Position of this lane in the bundle
    parameter int unsigned LANE = 0
) (
    // Request in flight from the PC generator
    input  logic                         req_valid_i,
    input  logic [`ADDR_WIDTH-1:0]       req_pc_i,
    input  logic [`LANE_IDX_WIDTH-1:0]   req_last_lane_i,
    // Block returned by this lane's memory port
    input  logic [`BLOCK_WIDTH-1:0]      block_i,
    // Lane result to the bundle register
    output logic                         lane_valid_o,
    output logic [`ADDR_WIDTH-1:0]       lane_pc_o,
    output logic [`ADDR_WIDTH-1:0]       lane_npc_o,
    output inst_t                        lane_inst_o
);

    // Byte offset of this lane from the bundle PC
    localparam logic [`ADDR_WIDTH-1:0] PC_OFFSET = 4 * LANE;

    inst_t word;

    // ------------------------------------------------------------------
    // Addresses
    // ------------------------------------------------------------------

    assign lane_pc_o  = req_pc_i + PC_OFFSET;

    // Fall-through address, prediction handled by the PC generator
    assign lane_npc_o = lane_pc_o + `ADDR_WIDTH'(4);

    // ------------------------------------------------------------------
    // Word select and masking
    // ------------------------------------------------------------------

    // PC bit 2 picks the half of the 64-bit block
    always_comb begin
        if (lane_pc_o[2]) begin
            word = block_i[63:32];
        end else begin
            word = block_i[31:0];
        end
    end

    // Lanes past the taken branch drop out
    assign lane_valid_o = req_valid_i && (int'(req_last_lane_i) >= LANE);

    // Invalid lanes carry a NOP
    assign lane_inst_o  = lane_valid_o ? word : inst_t'(`NOP);

endmodule

// ==== src/imem.sv ====
// Banked instruction memory: testbench write port and one registered block read per fetch lane
`timescale 1ns/1ps
`include "fetch_defs.svh"

module imem import fetch_pkg::*; (
    input  logic                                          clock,
    // Read strobe and base PC from the PC generator
    input  mem_command_e                                  imem_command_i,
    input  logic [`ADDR_WIDTH-1:0]                        imem_addr_i,
    // Block write port, driven by the testbench
    input  logic                                          load_en_i,
    input  logic [`IMEM_ADDR_WIDTH-1:0]                   load_addr_i,
    input  logic [`BLOCK_WIDTH-1:0]                       load_data_i,
    // One block per lane, valid the cycle after MEM_LOAD
    output logic [`FETCH_WIDTH-1:0][`BLOCK_WIDTH-1:0]     blocks_o
);

    // Block storage, no reset
    logic [`BLOCK_WIDTH-1:0] mem [`IMEM_DEPTH];

    // ------------------------------------------------------------------
    // Write port
    // ------------------------------------------------------------------

    always_ff @(posedge clock) begin
        if (load_en_i) begin
            mem[load_addr_i] <= load_data_i;
        end
    end

    // ------------------------------------------------------------------
    // Read ports, one per lane
    // ------------------------------------------------------------------

    for (genvar l = 0; l < `FETCH_WIDTH; l++) begin : g_port
        logic [`ADDR_WIDTH-1:0]      port_addr;
        logic [`IMEM_ADDR_WIDTH-1:0] port_idx;
        logic [`BLOCK_WIDTH-1:0]     port_q;

        // Byte address of this lane's word
        assign port_addr = imem_addr_i + `ADDR_WIDTH'(4 * l);

        // Block index drops the byte offset, upper bits wrap
        assign port_idx = port_addr[`IMEM_ADDR_WIDTH+2:3];

        // Holds last read when no load is issued
        always_ff @(posedge clock) begin
            if (imem_command_i == MEM_LOAD) begin
                port_q <= mem[port_idx];
            end
        end

        assign blocks_o[l] = port_q;

        // Testbench writes must not race a fetch of the same block
        a_no_write_collision: assert property (
            @(posedge clock)
            (imem_command_i == MEM_LOAD) |-> !(load_en_i && (load_addr_i == port_idx))
        );
    end

endmodule

// ==== src/fetch_pc.sv ====
// PC generator for the fetch unit: next-PC priority, memory load strobe and request register
`timescale 1ns/1ps
`include "fetch_defs.svh"

module fetch_pc import fetch_pkg::*; (
    input  logic                         clock,
    input  logic                         reset,
    // Low stalls the PC and suppresses the load
    input  logic                         fetch_en_i,
    // Redirect from a later stage, highest priority
    input  logic                         flush_i,
    input  logic [`ADDR_WIDTH-1:0]       flush_target_i,
    // Prediction for the bundle at the current PC
    input  logic                         pred_valid_i,
    input  logic                         pred_taken_i,
    input  logic [`LANE_IDX_WIDTH-1:0]   pred_lane_i,
    input  logic [`ADDR_WIDTH-1:0]       pred_target_i,
    // To the instruction memory
    output mem_command_e                 imem_command_o,
    output logic [`ADDR_WIDTH-1:0]       imem_addr_o,
    // Request in flight, lines up with the memory read data
    output logic                         req_valid_o,
    output logic [`ADDR_WIDTH-1:0]       req_pc_o,
    output logic [`LANE_IDX_WIDTH-1:0]   req_last_lane_o
);

    localparam int unsigned LANE_W = `LANE_IDX_WIDTH;

    // Bytes covered by one full bundle
    localparam logic [`ADDR_WIDTH-1:0] PC_STEP = 4 * `FETCH_WIDTH;

    // Highest lane when no branch cuts the bundle
    localparam logic [LANE_W-1:0] LAST_LANE = LANE_W'(`FETCH_WIDTH - 1);

    logic [`ADDR_WIDTH-1:0] pc_q;
    logic [`ADDR_WIDTH-1:0] pc_next;
    logic                   pred_hit;
    logic                   load;

    // ------------------------------------------------------------------
    // Next PC
    // ------------------------------------------------------------------

    assign pred_hit = pred_valid_i && pred_taken_i;

    // Flush, then taken prediction, then sequential; stall holds
    always_comb begin
        pc_next = pc_q;
        if (flush_i) begin
            pc_next = flush_target_i;
        end else if (fetch_en_i) begin
            if (pred_hit) begin
                pc_next = pred_target_i;
            end else begin
                pc_next = pc_q + PC_STEP;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            pc_q <= `RESET_PC;
        end else begin
            pc_q <= pc_next;
        end
    end

    // ------------------------------------------------------------------
    // Load strobe and request register
    // ------------------------------------------------------------------

    // One load per enabled cycle, none while flushing
    assign load           = !reset && !flush_i && fetch_en_i;
    assign imem_command_o = load ? MEM_LOAD : MEM_NONE;
    assign imem_addr_o    = pc_q;

    // Valid bit killed by flush so the older read never reaches the lanes
    always_ff @(posedge clock) begin
        if (reset || flush_i) begin
            req_valid_o <= 1'b0;
        end else begin
            req_valid_o <= load;
        end
    end

    // PC and cut lane follow the memory read
    always_ff @(posedge clock) begin
        if (load) begin
            req_pc_o        <= pc_q;
            req_last_lane_o <= pred_hit ? pred_lane_i : LAST_LANE;
        end
    end

    // Predictor must name a lane that exists in the bundle
    a_pred_lane_in_range: assert property (
        @(posedge clock) disable iff (reset)
        pred_valid_i |-> (int'(pred_lane_i) < `FETCH_WIDTH)
    );

endmodule

// ==== src/fetch_pkg.sv ====
// Types shared by the fetch RTL; import by wildcard in the module header
package fetch_pkg;

    // ------------------------------------------------------------------
    // Memory command
    // ------------------------------------------------------------------

    // Single-cycle strobe to the instruction memory, no acknowledge
    typedef enum logic [1:0] {
        // No read this cycle
        MEM_NONE = 2'h0,
        // Read the blocks for the current PC
        MEM_LOAD = 2'h1
    } mem_command_e;

    // ------------------------------------------------------------------
    // Instruction word
    // ------------------------------------------------------------------

    // One 32-bit RISC-V instruction
    typedef logic [31:0] inst_t;

endpackage

// ==== src/fetch_defs.svh ====
// Shared widths, reset PC and NOP encoding for the fetch subsystem; include in every RTL file
`ifndef FETCH_DEFS_SVH
`define FETCH_DEFS_SVH

// ----------------------------------------------------------------------
// Fetch geometry
// ----------------------------------------------------------------------

// Instructions fetched per cycle
`define FETCH_WIDTH 2

// Lane index width, kept at least one bit wide
`define LANE_IDX_WIDTH ((`FETCH_WIDTH > 1) ? $clog2(`FETCH_WIDTH) : 1)

// Byte address width
`define ADDR_WIDTH 32

// ----------------------------------------------------------------------
// Instruction memory
// ----------------------------------------------------------------------

// One memory block holds two 32-bit words
`define BLOCK_WIDTH 64

// Number of blocks, 2 KB of address space
`define IMEM_DEPTH 256
`define IMEM_ADDR_WIDTH $clog2(`IMEM_DEPTH)

// PC after reset
`define RESET_PC 32'h0000_0000

// addi x0, x0, 0 placed in invalid lanes
`define NOP 32'h0000_0013

`endif
